// File: hdl/murn_pkg.sv
// ring node shared definitions

`default_nettype none

package murn_pkg;

   // number of ring nodes served by the bridge
   localparam int NODES = 2;

   // operand, tag and result widths
   localparam int OPND_W = 12;
   localparam int TAG_W  = 6;
   localparam int VAL_W  = 24;

   // opcodes understood by the compute block
   typedef enum logic [1:0]
   {
      // zero-extended sum
      OP_ADD = 2'd0,
      // difference modulo 2^24
      OP_SUB = 2'd1,
      // zero-extended exclusive or
      OP_XOR = 2'd2,
      // full product of the two operands
      OP_MUL = 2'd3
   } murn_op_e;

   // request flit from host to node, 32 bits
   typedef struct packed
   {
      murn_op_e          op;
      logic [TAG_W-1:0]  tag;
      logic [OPND_W-1:0] a;
      logic [OPND_W-1:0] b;
   } req_flit_t;

   // result flit from node back to host, 32 bits
   // tag and op are echoed from the request
   typedef struct packed
   {
      logic [TAG_W-1:0] tag;
      murn_op_e         op;
      logic [VAL_W-1:0] value;
   } rsp_flit_t;

endpackage

`default_nettype wire

// File: hdl/murn_two_fifo.sv
// two entry flit fifo

`default_nettype none

module murn_two_fifo
#(
   parameter type payload_t = logic [31:0]
)
(
   input  wire logic     clk_i,
   input  wire logic     rst_n_i,

   // valid/ready producer side
   input  wire logic     v_i,
   output logic          ready_o,
   input  wire payload_t data_i,

   // valid/yumi consumer side
   output logic          v_o,
   output payload_t      data_o,
   input  wire logic     yumi_i
);

   // payload storage
   payload_t mem_r [2];

   logic wr_ptr_r;
   logic rd_ptr_r;
   logic full_r;
   logic empty_r;

   logic push;
   logic pop;

   // a full fifo takes a new item only on the cycle it pops
   assign ready_o = ~full_r | yumi_i;
   assign push    = v_i & ready_o;
   assign pop     = yumi_i;

   assign v_o    = ~empty_r;
   assign data_o = mem_r[rd_ptr_r];

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_r <= 1'b0;
         rd_ptr_r <= 1'b0;
         full_r   <= 1'b0;
         empty_r  <= 1'b1;
      end
      else
      begin
         if (push)
         begin
            wr_ptr_r <= ~wr_ptr_r;
         end
         if (pop)
         begin
            rd_ptr_r <= ~rd_ptr_r;
         end

         // occupancy only moves when exactly one side acts
         if (push && !pop)
         begin
            empty_r <= 1'b0;
            full_r  <= (~wr_ptr_r == rd_ptr_r);
         end
         else if (pop && !push)
         begin
            full_r  <= 1'b0;
            empty_r <= (~rd_ptr_r == wr_ptr_r);
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (push)
      begin
         mem_r[wr_ptr_r] <= data_i;
      end
   end

   // equal pointers mean exactly one of full or empty
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
                    (wr_ptr_r == rd_ptr_r) == (full_r ^ empty_r))
      else $error("two_fifo: occupancy flags disagree with pointers");

   // the consumer may only pop an item that is there
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
                    yumi_i |-> v_o)
      else $error("two_fifo: yumi without valid");

endmodule

`default_nettype wire

// File: hdl/murn_converter.sv
// ring flow control bridge

`default_nettype none

module murn_converter
(
   input  wire logic                     clk_i,
   input  wire logic                     rst_n_i,

   // upstream request buffers, valid/yumi
   input  wire logic [murn_pkg::NODES-1:0] req_v_i,
   output logic      [murn_pkg::NODES-1:0] req_yumi_o,
   input  wire murn_pkg::req_flit_t        req_i [murn_pkg::NODES],

   // switch to block, valid then retry
   output logic      [murn_pkg::NODES-1:0] sw2blk_valid_o,
   input  wire logic [murn_pkg::NODES-1:0] sw2blk_retry_i,
   output murn_pkg::req_flit_t             sw2blk_data_o [murn_pkg::NODES],

   // block to switch, retry then valid
   input  wire logic [murn_pkg::NODES-1:0] blk2sw_valid_i,
   output logic      [murn_pkg::NODES-1:0] blk2sw_retry_o,
   input  wire murn_pkg::rsp_flit_t        blk2sw_data_i [murn_pkg::NODES],

   // host result side, valid/yumi
   output logic      [murn_pkg::NODES-1:0] resp_v_o,
   input  wire logic [murn_pkg::NODES-1:0] resp_yumi_i,
   output murn_pkg::rsp_flit_t             resp_o [murn_pkg::NODES]
);

   logic [murn_pkg::NODES-1:0] rsp_ready;
   logic [murn_pkg::NODES-1:0] rsp_push;

   // request path adds no cycle
   // the buffer head is offered and popped once the block stops retrying
   assign sw2blk_valid_o = req_v_i;
   assign req_yumi_o     = req_v_i & ~sw2blk_retry_i;

   // retry comes from fifo state first, the block picks its valid after
   assign blk2sw_retry_o = ~rsp_ready;
   assign rsp_push       = blk2sw_valid_i & ~blk2sw_retry_o;

   for (genvar i = 0; i < murn_pkg::NODES; i++)
   begin : g_node
      assign sw2blk_data_o[i] = req_i[i];

      // the retry->valid output needs two slots to present as valid/yumi
      murn_two_fifo
      #(
         .payload_t (murn_pkg::rsp_flit_t)
      )
      u_rsp_fifo
      (
         .clk_i   (clk_i),
         .rst_n_i (rst_n_i),
         .v_i     (rsp_push[i]),
         .ready_o (rsp_ready[i]),
         .data_i  (blk2sw_data_i[i]),
         .v_o     (resp_v_o[i]),
         .data_o  (resp_o[i]),
         .yumi_i  (resp_yumi_i[i])
      );

      // ring retry is only raised by a full result fifo the host is not draining
      assert property (@(posedge clk_i) disable iff (!rst_n_i)
                       blk2sw_retry_o[i] |-> (resp_v_o[i] && !resp_yumi_i[i]))
         else $error("converter: ring retry without a stalled result fifo");
   end

endmodule

`default_nettype wire

// File: hdl/murn_alu_block.sv
// per node arithmetic block

`default_nettype none

module murn_alu_block
(
   input  wire logic                clk_i,
   input  wire logic                rst_n_i,

   // request in from switch, valid then retry
   input  wire logic                sw2blk_valid_i,
   output logic                     sw2blk_retry_o,
   input  wire murn_pkg::req_flit_t sw2blk_data_i,

   // result out to switch, retry then valid
   output logic                     blk2sw_valid_o,
   input  wire logic                blk2sw_retry_i,
   output murn_pkg::rsp_flit_t      blk2sw_data_o
);

   // output register
   logic                out_v_r;
   murn_pkg::rsp_flit_t out_r;

   logic                     accept;
   logic [murn_pkg::VAL_W-1:0] a_ext;
   logic [murn_pkg::VAL_W-1:0] b_ext;
   logic [murn_pkg::VAL_W-1:0] value_d;

   // busy only while holding a result the switch keeps retrying
   assign sw2blk_retry_o = out_v_r & blk2sw_retry_i;
   assign accept         = sw2blk_valid_i & ~sw2blk_retry_o;

   assign blk2sw_valid_o = out_v_r;
   assign blk2sw_data_o  = out_r;

   // operands widened to result width
   assign a_ext = {{(murn_pkg::VAL_W - murn_pkg::OPND_W){1'b0}}, sw2blk_data_i.a};
   assign b_ext = {{(murn_pkg::VAL_W - murn_pkg::OPND_W){1'b0}}, sw2blk_data_i.b};

   always_comb
   begin
      value_d = '0;
      unique case (sw2blk_data_i.op)
         murn_pkg::OP_ADD:
         begin
            value_d = a_ext + b_ext;
         end
         murn_pkg::OP_SUB:
         begin
            // wraps modulo 2^24
            value_d = a_ext - b_ext;
         end
         murn_pkg::OP_XOR:
         begin
            value_d = a_ext ^ b_ext;
         end
         murn_pkg::OP_MUL:
         begin
            // 12x12 product always fits in 24 bits
            value_d = a_ext * b_ext;
         end
      endcase
   end

   // valid reloads whenever the register is empty or draining
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         out_v_r <= 1'b0;
      end
      else if (!sw2blk_retry_o)
      begin
         out_v_r <= sw2blk_valid_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         out_r.tag   <= sw2blk_data_i.tag;
         out_r.op    <= sw2blk_data_i.op;
         out_r.value <= value_d;
      end
   end

   // a retried result is held as is
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
                    (blk2sw_valid_o && blk2sw_retry_i) |=> $stable(blk2sw_data_o))
      else $error("alu_block: held result changed while retried");

   // and it does not drop its valid before it transfers
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
                    (blk2sw_valid_o && blk2sw_retry_i) |=> blk2sw_valid_o)
      else $error("alu_block: valid dropped while retried");

endmodule

`default_nettype wire

// File: hdl/murn_node_array_top.sv
// ring node array top level

`default_nettype none

module murn_node_array_top
(
   input  wire logic                       clk_i,
   input  wire logic                       rst_n_i,

   // host requests, valid/ready
   input  wire logic [murn_pkg::NODES-1:0] req_v_i,
   output logic      [murn_pkg::NODES-1:0] req_ready_o,
   input  wire murn_pkg::req_flit_t        req_i [murn_pkg::NODES],

   // host results, valid/yumi
   output logic      [murn_pkg::NODES-1:0] resp_v_o,
   input  wire logic [murn_pkg::NODES-1:0] resp_yumi_i,
   output murn_pkg::rsp_flit_t             resp_o [murn_pkg::NODES]
);

   // request buffer heads
   logic [murn_pkg::NODES-1:0] req_buf_v;
   logic [murn_pkg::NODES-1:0] req_buf_yumi;
   murn_pkg::req_flit_t        req_buf_data [murn_pkg::NODES];

   // ring side of each node
   logic [murn_pkg::NODES-1:0] sw2blk_valid;
   logic [murn_pkg::NODES-1:0] sw2blk_retry;
   murn_pkg::req_flit_t        sw2blk_data [murn_pkg::NODES];
   logic [murn_pkg::NODES-1:0] blk2sw_valid;
   logic [murn_pkg::NODES-1:0] blk2sw_retry;
   murn_pkg::rsp_flit_t        blk2sw_data [murn_pkg::NODES];

   // input side
   for (genvar i = 0; i < murn_pkg::NODES; i++)
   begin : g_req
      murn_two_fifo
      #(
         .payload_t (murn_pkg::req_flit_t)
      )
      u_req_fifo
      (
         .clk_i   (clk_i),
         .rst_n_i (rst_n_i),
         .v_i     (req_v_i[i]),
         .ready_o (req_ready_o[i]),
         .data_i  (req_i[i]),
         .v_o     (req_buf_v[i]),
         .data_o  (req_buf_data[i]),
         .yumi_i  (req_buf_yumi[i])
      );
   end

   murn_converter u_converter
   (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .req_v_i        (req_buf_v),
      .req_yumi_o     (req_buf_yumi),
      .req_i          (req_buf_data),
      .sw2blk_valid_o (sw2blk_valid),
      .sw2blk_retry_i (sw2blk_retry),
      .sw2blk_data_o  (sw2blk_data),
      .blk2sw_valid_i (blk2sw_valid),
      .blk2sw_retry_o (blk2sw_retry),
      .blk2sw_data_i  (blk2sw_data),
      .resp_v_o       (resp_v_o),
      .resp_yumi_i    (resp_yumi_i),
      .resp_o         (resp_o)
   );

   // processing part
   for (genvar i = 0; i < murn_pkg::NODES; i++)
   begin : g_alu
      murn_alu_block u_alu
      (
         .clk_i          (clk_i),
         .rst_n_i        (rst_n_i),
         .sw2blk_valid_i (sw2blk_valid[i]),
         .sw2blk_retry_o (sw2blk_retry[i]),
         .sw2blk_data_i  (sw2blk_data[i]),
         .blk2sw_valid_o (blk2sw_valid[i]),
         .blk2sw_retry_i (blk2sw_retry[i]),
         .blk2sw_data_o  (blk2sw_data[i])
      );
   end

endmodule

`default_nettype wire

// File: verification/murn_tb.sv
// ring node array testbench

`default_nettype none

module murn_tb;

   localparam int          CLK_PERIOD  = 20;
   localparam int          DRIVE_DLY   = 2;
   localparam int          TIMEOUT_CYC = 20000;
   localparam int          N_STREAM    = 300;
   localparam int          N_BURST     = 32;
   localparam logic [31:0] LFSR_SEED   = 32'hae62_4943;

   logic                       clk;
   logic                       rst_n;
   logic [murn_pkg::NODES-1:0] req_v;
   logic [murn_pkg::NODES-1:0] req_ready;
   murn_pkg::req_flit_t        req [murn_pkg::NODES];
   logic [murn_pkg::NODES-1:0] resp_v;
   logic [murn_pkg::NODES-1:0] resp_yumi;
   murn_pkg::rsp_flit_t        resp [murn_pkg::NODES];

   logic [31:0] lfsr_state;

   // expected results per node, in request order
   murn_pkg::rsp_flit_t exp_q [murn_pkg::NODES][$];

   murn_node_array_top UUT
   (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .req_v_i     (req_v),
      .req_ready_o (req_ready),
      .req_i       (req),
      .resp_v_o    (resp_v),
      .resp_yumi_i (resp_yumi),
      .resp_o      (resp)
   );

   always
   begin
      #(CLK_PERIOD / 2);
      clk = ~clk;
   end

   // taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++)
      begin
         lfsr_state = lfsr_step(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   function automatic murn_pkg::req_flit_t random_flit();
      murn_pkg::req_flit_t r;
      logic [31:0]         bits;
      bits  = rand_bits(2);
      r.op  = murn_pkg::murn_op_e'(bits[1:0]);
      bits  = rand_bits(murn_pkg::TAG_W);
      r.tag = bits[murn_pkg::TAG_W-1:0];
      bits  = rand_bits(murn_pkg::OPND_W);
      r.a   = bits[murn_pkg::OPND_W-1:0];
      bits  = rand_bits(murn_pkg::OPND_W);
      r.b   = bits[murn_pkg::OPND_W-1:0];
      return r;
   endfunction

   // reference model, 32 bit arithmetic cut down to the result width
   function automatic murn_pkg::rsp_flit_t expected_rsp(input murn_pkg::req_flit_t r);
      murn_pkg::rsp_flit_t e;
      int unsigned         a;
      int unsigned         b;
      int unsigned         v;
      a = {20'd0, r.a};
      b = {20'd0, r.b};
      case (r.op)
         murn_pkg::OP_ADD: v = a + b;
         murn_pkg::OP_SUB: v = a - b;
         murn_pkg::OP_XOR: v = a ^ b;
         murn_pkg::OP_MUL: v = a * b;
         default:          v = 0;
      endcase
      e.tag   = r.tag;
      e.op    = r.op;
      e.value = v[23:0];
      return e;
   endfunction

   task automatic report_mismatch(input string msg);
      $display("error at time %0t: %s", $time, msg);
      $display("TB FAILED");
      $fatal(1, "stopped at the first mismatch");
   endtask

   task automatic abort_on_timeout(input string what);
      $display("TB FAILED");
      $fatal(1, "timed out while waiting for %s", what);
   endtask

   task automatic to_drive_point();
      @(posedge clk);
      #DRIVE_DLY;
   endtask

   task automatic wait_ready(input int n);
      int cnt;
      cnt = 0;
      @(negedge clk);
      while (!req_ready[n])
      begin
         cnt++;
         if (cnt > TIMEOUT_CYC)
         begin
            abort_on_timeout($sformatf("req_ready_o on node %0d", n));
         end
         @(negedge clk);
      end
   endtask

   // scoreboard, sampled mid cycle while everything is settled
   always @(negedge clk)
   begin
      murn_pkg::rsp_flit_t head;
      if (rst_n)
      begin
         for (int n = 0; n < murn_pkg::NODES; n++)
         begin
            if (req_v[n] && req_ready[n])
            begin
               exp_q[n].push_back(expected_rsp(req[n]));
            end
            if (resp_v[n] && resp_yumi[n])
            begin
               assert (exp_q[n].size() > 0)
                  else report_mismatch($sformatf("node %0d popped an unexpected result", n));
               head = exp_q[n].pop_front();
               assert (resp[n] == head)
                  else report_mismatch($sformatf("node %0d got %h, expected %h",
                                                 n, resp[n], head));
            end
         end
      end
   end

   task automatic check_idle_outputs(input string when_s);
      assert (resp_v == '0)
         else report_mismatch({"resp_v_o not low ", when_s});
      assert (req_ready == '1)
         else report_mismatch({"req_ready_o not high ", when_s});
      assert (UUT.sw2blk_retry == '0 && UUT.blk2sw_retry == '0)
         else report_mismatch({"ring retry raised ", when_s});
      assert (UUT.blk2sw_valid == '0 && UUT.req_buf_v == '0)
         else report_mismatch({"internal valid raised ", when_s});
   endtask

   task automatic check_reset_state();
      rst_n = 1'b0;
      for (int c = 0; c < 4; c++)
      begin
         to_drive_point();
         check_idle_outputs("in reset");
      end
      rst_n = 1'b1;
      to_drive_point();
      check_idle_outputs("after reset");
   endtask

   // one request alone, result must show exactly two edges after acceptance
   task automatic single_request(input int n, input murn_pkg::murn_op_e op,
                                 input logic [murn_pkg::OPND_W-1:0] a,
                                 input logic [murn_pkg::OPND_W-1:0] b,
                                 input logic [murn_pkg::TAG_W-1:0] tag);
      murn_pkg::req_flit_t r;
      murn_pkg::rsp_flit_t e;
      int                  edges;
      r.op     = op;
      r.tag    = tag;
      r.a      = a;
      r.b      = b;
      e        = expected_rsp(r);
      req[n]   = r;
      req_v[n] = 1'b1;
      wait_ready(n);
      to_drive_point();
      req_v[n] = 1'b0;
      edges    = 0;
      while (!resp_v[n])
      begin
         to_drive_point();
         edges++;
         if (edges > TIMEOUT_CYC)
         begin
            abort_on_timeout($sformatf("resp_v_o on node %0d", n));
         end
      end
      assert (edges == 2)
         else report_mismatch($sformatf("node %0d result after %0d edges", n, edges));
      assert (resp[n] == e)
         else report_mismatch($sformatf("node %0d op %0d a %0d b %0d gave %h, expected %h",
                                        n, op, a, b, resp[n], e));
      resp_yumi[n] = 1'b1;
      to_drive_point();
      resp_yumi[n] = 1'b0;
   endtask

   task automatic run_opcode_checks();
      logic [murn_pkg::OPND_W-1:0] a_set [5];
      logic [murn_pkg::OPND_W-1:0] b_set [5];
      logic [murn_pkg::TAG_W-1:0]  tag;
      a_set = '{12'd0, 12'd4095, 12'd0, 12'd4095, 12'd2748};
      b_set = '{12'd0, 12'd4095, 12'd4095, 12'd0, 12'd1365};
      tag   = '0;
      for (int n = 0; n < murn_pkg::NODES; n++)
      begin
         for (int o = 0; o < 4; o++)
         begin
            for (int k = 0; k < 5; k++)
            begin
               single_request(n, murn_pkg::murn_op_e'(o[1:0]), a_set[k], b_set[k], tag);
               tag++;
            end
         end
      end
   endtask

   // node 0 stalls on its result side while node 1 keeps moving
   task automatic run_backpressure();
      int                         accepted;
      int                         stalled;
      int                         drained;
      int                         other_pops;
      int                         cnt;
      logic [murn_pkg::NODES-1:0] took;
      accepted   = 0;
      stalled    = 0;
      other_pops = 0;
      cnt        = 0;
      req[0]     = random_flit();
      req[1]     = random_flit();
      req_v      = '1;
      resp_yumi  = '0;
      while (stalled < 8)
      begin
         @(negedge clk);
         took = req_v & req_ready;
         if (took[0])
         begin
            accepted++;
         end
         else
         begin
            stalled++;
         end
         if (resp_v[1] && resp_yumi[1])
         begin
            other_pops++;
         end
         cnt++;
         if (cnt > TIMEOUT_CYC)
         begin
            abort_on_timeout("req_ready_o to fall on node 0");
         end
         to_drive_point();
         if (took[0])
         begin
            req[0] = random_flit();
         end
         if (took[1])
         begin
            req[1] = random_flit();
         end
         resp_yumi[1] = resp_v[1];
      end
      assert (accepted == 5)
         else report_mismatch($sformatf("node 0 took %0d requests under stall", accepted));
      assert (other_pops > 0)
         else report_mismatch("node 1 stopped while node 0 stalled");

      // release and drain in order
      req_v     = '0;
      resp_yumi = resp_v;
      drained   = 0;
      cnt       = 0;
      while (exp_q[0].size() != 0 || exp_q[1].size() != 0)
      begin
         @(negedge clk);
         if (resp_v[0] && resp_yumi[0])
         begin
            drained++;
         end
         cnt++;
         if (cnt > TIMEOUT_CYC)
         begin
            abort_on_timeout("the stalled node to drain");
         end
         to_drive_point();
         resp_yumi = resp_v;
      end
      assert (drained == 5)
         else report_mismatch($sformatf("node 0 drained %0d results", drained));
      resp_yumi = '0;
   endtask

   task automatic run_streaming();
      int                         sent [murn_pkg::NODES];
      logic [murn_pkg::NODES-1:0] took;
      logic [31:0]                bits;
      int                         cnt;
      logic                       busy;
      for (int n = 0; n < murn_pkg::NODES; n++)
      begin
         sent[n] = 0;
      end
      took = '0;
      cnt  = 0;
      busy = 1'b1;
      while (busy)
      begin
         for (int n = 0; n < murn_pkg::NODES; n++)
         begin
            // a held request stays until taken
            if (!req_v[n] || took[n])
            begin
               bits     = rand_bits(2);
               req_v[n] = (sent[n] < N_STREAM) && (bits[1:0] != 2'd0);
               req[n]   = random_flit();
            end
            bits         = rand_bits(2);
            resp_yumi[n] = resp_v[n] && (bits[1:0] != 2'd0);
         end
         @(negedge clk);
         took = req_v & req_ready;
         for (int n = 0; n < murn_pkg::NODES; n++)
         begin
            if (took[n])
            begin
               sent[n]++;
            end
         end
         cnt++;
         if (cnt > TIMEOUT_CYC)
         begin
            abort_on_timeout("the random stream to finish");
         end
         to_drive_point();
         busy = 1'b0;
         for (int n = 0; n < murn_pkg::NODES; n++)
         begin
            if (sent[n] < N_STREAM || exp_q[n].size() != 0)
            begin
               busy = 1'b1;
            end
         end
      end
      req_v     = '0;
      resp_yumi = '0;
   endtask

   task automatic run_full_throughput();
      int   accepted [murn_pkg::NODES];
      logic exp_v;
      for (int n = 0; n < murn_pkg::NODES; n++)
      begin
         accepted[n] = 0;
         req[n]      = random_flit();
      end
      req_v     = '1;
      resp_yumi = '0;
      for (int c = 0; c < N_BURST + 4; c++)
      begin
         @(negedge clk);
         // first request moves at the edge closing cycle 0, shows two edges later
         exp_v = (c >= 3) && (c < N_BURST + 3);
         for (int n = 0; n < murn_pkg::NODES; n++)
         begin
            assert (!req_v[n] || req_ready[n])
               else report_mismatch($sformatf("req_ready_o fell on node %0d", n));
            assert (resp_v[n] == exp_v)
               else report_mismatch($sformatf("node %0d resp_v_o %0b in cycle %0d",
                                              n, resp_v[n], c));
            if (req_v[n])
            begin
               accepted[n]++;
            end
         end
         to_drive_point();
         for (int n = 0; n < murn_pkg::NODES; n++)
         begin
            req_v[n]     = accepted[n] < N_BURST;
            req[n]       = random_flit();
            resp_yumi[n] = resp_v[n];
         end
      end
      req_v     = '0;
      resp_yumi = '0;
   endtask

   initial
   begin
      int outstanding;
      clk       = 1'b0;
      rst_n     = 1'b0;
      req_v     = '0;
      resp_yumi = '0;
      for (int n = 0; n < murn_pkg::NODES; n++)
      begin
         req[n] = '0;
      end
      lfsr_state = LFSR_SEED;

      check_reset_state();
      run_opcode_checks();
      run_backpressure();
      run_streaming();
      run_full_throughput();

      outstanding = 0;
      for (int n = 0; n < murn_pkg::NODES; n++)
      begin
         outstanding += exp_q[n].size();
      end
      if (outstanding == 0)
      begin
         $display("TB PASSED");
         $finish;
      end
      else
      begin
         $display("TB FAILED");
         $fatal(1, "%0d results never arrived", outstanding);
      end
   end

endmodule

`default_nettype wire

// File: vlog.f
hdl/murn_pkg.sv
hdl/murn_two_fifo.sv
hdl/murn_converter.sv
hdl/murn_alu_block.sv
hdl/murn_node_array_top.sv
verification/murn_tb.sv

// File: run.sh
#!/bin/sh
# build and run the ring node array testbench with Verilator
# the exit status of the simulation is the pass or fail result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module murn_tb \
   -f vlog.f

./obj_dir/Vmurn_tb
